/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tx_split_tb -f tx_split_top.f
	@out=$$(./obj_dir/Vtx_split_tb); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* logic/beat_fifo.sv */
module beat_fifo (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  tx_split_types_pkg::data_t in_data,
    input  tx_split_types_pkg::keep_t in_keep,
    input  logic                      in_last,
    beat_if.src                       rd
);
    import tx_split_cfg_pkg::*;
    import tx_split_types_pkg::*;

    data_t data_mem [2**FIFO_DEPTH_BITS];
    keep_t keep_mem [2**FIFO_DEPTH_BITS];
    logic  last_mem [2**FIFO_DEPTH_BITS];

    // extra msb tells full from empty
    logic [FIFO_DEPTH_BITS:0]   wr_ptr;
    logic [FIFO_DEPTH_BITS:0]   rd_ptr;
    logic [FIFO_DEPTH_BITS-1:0] wr_addr;
    logic [FIFO_DEPTH_BITS-1:0] rd_addr;
    logic                       full;
    logic                       empty;
    logic                       wr_en;
    logic                       rd_en;

    assign wr_addr = wr_ptr[FIFO_DEPTH_BITS-1:0];
    assign rd_addr = rd_ptr[FIFO_DEPTH_BITS-1:0];

    assign full  = (wr_ptr[FIFO_DEPTH_BITS] != rd_ptr[FIFO_DEPTH_BITS]) && (wr_addr == rd_addr);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready = !full;
    assign wr_en    = in_valid && in_ready;
    assign rd_en    = rd.valid && rd.ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_addr] <= in_data;
            keep_mem[wr_addr] <= in_keep;
            last_mem[wr_addr] <= in_last;
        end
    end

    // fall-through read, head entry visible while not empty
    assign rd.valid = !empty;
    assign rd.data  = data_mem[rd_addr];
    assign rd.keep  = keep_mem[rd_addr];
    assign rd.last  = last_mem[rd_addr];

endmodule

/* logic/cmd_decode.sv */
module cmd_decode (
    input  logic                      clk,
    input  logic                      rstn,
    input  tx_split_types_pkg::meta_t meta_data,
    seg_if.dec                        seg
);
    import tx_split_cfg_pkg::*;
    import tx_split_types_pkg::*;

    len_t        rem_len;     // bytes not yet granted
    session_t    session_q;
    logic [15:0] seg_len;

    //////////////////////////////////////////////////////////////////////
    // command state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rem_len <= '0;
        end else if (seg.load) begin
            rem_len <= meta_data[47:16];
        end else if (seg.next) begin
            rem_len <= rem_len - len_t'(SEG_BYTES);   // one full segment gone
        end
    end

    // session only changes with a new command
    always_ff @(posedge clk) begin
        if (seg.load) begin
            session_q <= meta_data[15:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // header of the current segment
    //////////////////////////////////////////////////////////////////////

    assign seg.last_seg = (rem_len <= len_t'(SEG_BYTES));

    // remainder fits 16 bits once it is at most one segment
    assign seg_len = seg.last_seg ? rem_len[15:0] : 16'(SEG_BYTES);

    assign seg.hdr = {seg_len, session_q};

endmodule

/* logic/seg_cutter.sv */
module seg_cutter (
    input  logic                       clk,
    input  logic                       rstn,
    beat_if.dst                        rd,
    output logic                       out_valid,
    input  logic                       out_ready,
    output tx_split_types_pkg::data_t  out_data,
    output tx_split_types_pkg::keep_t  out_keep,
    output logic                       out_last,
    input  logic                       grant,
    output logic                       seg_done
);
    import tx_split_cfg_pkg::*;
    import tx_split_types_pkg::*;

    beat_cnt_t beat_cnt;      // beats already sent in this segment
    logic      out_xfer;
    logic      seg_full;

    //////////////////////////////////////////////////////////////////////
    // beat gating
    //////////////////////////////////////////////////////////////////////

    // nothing leaves the fifo without a granted segment
    assign out_valid = rd.valid && grant;
    assign rd.ready  = out_ready && grant;

    assign out_data = rd.data;
    assign out_keep = rd.keep;

    assign out_xfer = out_valid && out_ready;

    //////////////////////////////////////////////////////////////////////
    // segment boundary
    //////////////////////////////////////////////////////////////////////

    assign seg_full = (beat_cnt == beat_cnt_t'(SEG_BEATS - 1));

    // command end or full segment, whichever comes first
    assign out_last = rd.last || seg_full;

    assign seg_done = out_xfer && out_last;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (out_xfer) begin
            if (out_last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/seg_sequencer.sv */
module seg_sequencer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        meta_valid,
    output logic                        meta_ready,
    output logic                        hdr_valid,
    input  logic                        hdr_ready,
    output tx_split_types_pkg::hdr_t    hdr_data,
    input  logic                        st_in_valid,
    output logic                        st_in_ready,
    input  tx_split_types_pkg::status_t st_in_data,
    output logic                        st_out_valid,
    input  logic                        st_out_ready,
    output tx_split_types_pkg::status_t st_out_data,
    output logic                        grant,
    input  logic                        seg_done,
    seg_if.ctl                          seg
);
    import tx_split_types_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       st_xfer;
    logic       st_retry;
    logic       final_q;      // granted segment is the last of the command
    status_t    sts_q;

    assign meta_ready   = (state == IDLE);
    assign hdr_valid    = (state == HDR_SEND);
    assign st_in_ready  = (state == STS_WAIT);
    assign st_out_valid = (state == DONE);
    assign st_out_data  = sts_q;

    assign st_xfer  = st_in_valid && st_in_ready;
    assign st_retry = st_in_data[RETRY_BIT];

    // decoder strobes
    assign seg.load = meta_valid && meta_ready;
    assign seg.next = st_xfer && !st_retry && !seg.last_seg;

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (meta_valid) state_nxt = HDR_CALC;
            end
            HDR_CALC: begin
                state_nxt = HDR_SEND;
            end
            HDR_SEND: begin
                if (hdr_ready) state_nxt = STS_WAIT;
            end
            STS_WAIT: begin
                if (st_in_valid) begin
                    state_nxt = st_retry ? HDR_CALC : DATA_WAIT;   // retry resends same header
                end
            end
            DATA_WAIT: begin
                if (seg_done) state_nxt = final_q ? DONE : HDR_CALC;
            end
            DONE: begin
                if (st_out_ready) state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // grant and segment bookkeeping
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            grant   <= 1'b0;
            final_q <= 1'b0;
        end else if (st_xfer && !st_retry) begin
            grant   <= 1'b1;
            final_q <= seg.last_seg;
        end else if (seg_done) begin
            grant   <= 1'b0;                  // cutter closed the segment
        end
    end

    // header held stable through HDR_SEND
    always_ff @(posedge clk) begin
        if (state == HDR_CALC) begin
            hdr_data <= seg.hdr;
        end
    end

    // last granting status, returned upstream after the final segment
    always_ff @(posedge clk) begin
        if (st_xfer && !st_retry) begin
            sts_q <= st_in_data;
        end
    end

endmodule

/* logic/tx_split_cfg_pkg.sv */
package tx_split_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // payload path
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_BYTES      = 8;    // bytes per payload beat

    // largest payload one downstream header may announce
    localparam int SEG_BYTES       = 64;

    // beats in a full segment, used by the cutter for its forced lasts
    localparam int SEG_BEATS       = SEG_BYTES / DATA_BYTES;

    //////////////////////////////////////////////////////////////////////
    // buffering
    //////////////////////////////////////////////////////////////////////

    // beat fifo holds 2**FIFO_DEPTH_BITS entries
    localparam int FIFO_DEPTH_BITS = 5;

    //////////////////////////////////////////////////////////////////////
    // status channel
    //////////////////////////////////////////////////////////////////////

    localparam int STATUS_BITS     = 64;   // downstream and upstream status width

endpackage

/* logic/tx_split_ifs.sv */
// one payload beat between the fifo and the cutter
interface beat_if;
    import tx_split_types_pkg::*;

    logic  valid;
    logic  ready;
    data_t data;
    keep_t keep;
    logic  last;     // end of the whole command payload

    modport src (
        output valid,
        input  ready,
        output data,
        output keep,
        output last
    );

    modport dst (
        input  valid,
        output ready,
        input  data,
        input  keep,
        input  last
    );
endinterface

// segment control between the sequencer and the command decoder
interface seg_if;
    import tx_split_types_pkg::*;

    logic load;      // command accepted
    logic next;      // non-final segment granted, step to the next one
    hdr_t hdr;
    logic last_seg;  // remaining length fits one segment

    modport ctl (
        output load,
        output next,
        input  hdr,
        input  last_seg
    );

    modport dec (
        input  load,
        input  next,
        output hdr,
        output last_seg
    );
endinterface

/* logic/tx_split_top.sv */
module tx_split_top (
    input  logic                        clk,
    input  logic                        rstn,
    // command in
    input  logic                        meta_valid,
    output logic                        meta_ready,
    input  tx_split_types_pkg::meta_t   meta_data,
    // payload in
    input  logic                        in_valid,
    output logic                        in_ready,
    input  tx_split_types_pkg::data_t   in_data,
    input  tx_split_types_pkg::keep_t   in_keep,
    input  logic                        in_last,
    // header out
    output logic                        hdr_valid,
    input  logic                        hdr_ready,
    output tx_split_types_pkg::hdr_t    hdr_data,
    // payload out
    output logic                        out_valid,
    input  logic                        out_ready,
    output tx_split_types_pkg::data_t   out_data,
    output tx_split_types_pkg::keep_t   out_keep,
    output logic                        out_last,
    // downstream status in
    input  logic                        st_in_valid,
    output logic                        st_in_ready,
    input  tx_split_types_pkg::status_t st_in_data,
    // upstream status out
    output logic                        st_out_valid,
    input  logic                        st_out_ready,
    output tx_split_types_pkg::status_t st_out_data
);

    logic grant;       // segment granted by downstream status
    logic seg_done;    // last beat of a segment left

    beat_if bif ();
    seg_if  sif ();

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    cmd_decode u_cmd_decode (
        .clk       (clk),
        .rstn      (rstn),
        .meta_data (meta_data),
        .seg       (sif.dec)
    );

    seg_sequencer u_seg_sequencer (
        .clk          (clk),
        .rstn         (rstn),
        .meta_valid   (meta_valid),
        .meta_ready   (meta_ready),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .hdr_data     (hdr_data),
        .st_in_valid  (st_in_valid),
        .st_in_ready  (st_in_ready),
        .st_in_data   (st_in_data),
        .st_out_valid (st_out_valid),
        .st_out_ready (st_out_ready),
        .st_out_data  (st_out_data),
        .grant        (grant),
        .seg_done     (seg_done),
        .seg          (sif.ctl)
    );

    //////////////////////////////////////////////////////////////////////
    // payload path
    //////////////////////////////////////////////////////////////////////

    beat_fifo u_beat_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .in_keep  (in_keep),
        .in_last  (in_last),
        .rd       (bif.src)
    );

    seg_cutter u_seg_cutter (
        .clk       (clk),
        .rstn      (rstn),
        .rd        (bif.dst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .grant     (grant),
        .seg_done  (seg_done)
    );

endmodule

/* logic/tx_split_types_pkg.sv */
package tx_split_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // payload beat
    //////////////////////////////////////////////////////////////////////

    typedef logic [tx_split_cfg_pkg::DATA_BYTES*8-1:0] data_t;
    typedef logic [tx_split_cfg_pkg::DATA_BYTES-1:0]   keep_t;    // one bit per byte

    //////////////////////////////////////////////////////////////////////
    // command, header and status
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] len_t;        // byte count
    typedef logic [15:0] session_t;

    // {length[31:0], session[15:0]}
    typedef logic [47:0] meta_t;

    // {segment length[15:0], session[15:0]}
    typedef logic [31:0] hdr_t;

    typedef logic [tx_split_cfg_pkg::STATUS_BITS-1:0] status_t;

    localparam int RETRY_BIT = 63;     // set by downstream to ask for the header again

    // beat index inside one segment
    typedef logic [$clog2(tx_split_cfg_pkg::SEG_BEATS+1)-1:0] beat_cnt_t;

    //////////////////////////////////////////////////////////////////////
    // sequencer FSM
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        HDR_CALC,      // header registered from decoder
        HDR_SEND,
        STS_WAIT,
        DATA_WAIT,     // granted, beats flowing
        DONE           // final status waits for upstream
    } seq_state_t;

endpackage

/* tests/tx_split_model.svh */
`ifndef TX_SPLIT_MODEL_SVH
`define TX_SPLIT_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// expected traffic
//////////////////////////////////////////////////////////////////////

hdr_t    exp_hdr_q[$];      // front is the header of the open segment
logic    exp_final_q[$];    // header closes its command
data_t   exp_data_q[$];
keep_t   exp_keep_q[$];
logic    exp_last_q[$];
status_t exp_sts_q[$];      // granting status of each final segment

int hdr_errs   = 0;
int beat_errs  = 0;
int sts_errs   = 0;
int other_errs = 0;

// one header per segment, full segments first, remainder last
task automatic expect_headers(session_t session, len_t len);
    len_t rem;
    len_t seg_len;
    rem = len;
    while (rem != 0) begin
        seg_len = (rem > len_t'(SEG_BYTES)) ? len_t'(SEG_BYTES) : rem;
        exp_hdr_q.push_back({seg_len[15:0], session});
        exp_final_q.push_back(rem <= len_t'(SEG_BYTES));
        rem = rem - seg_len;
    end
endtask

// beat idx of n, closes a segment every SEG_BEATS beats and at the end
task automatic expect_beat(data_t data, keep_t keep, int idx, int n);
    exp_data_q.push_back(data);
    exp_keep_q.push_back(keep);
    exp_last_q.push_back((idx == n - 1) || (idx % SEG_BEATS == SEG_BEATS - 1));
endtask

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_hdr(string name, hdr_t exp, hdr_t act);
    if (act !== exp) begin
        hdr_errs++;
        $display("Error %s: expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_beat(string name, data_t exp_d, keep_t exp_k, logic exp_l,
                          data_t act_d, keep_t act_k, logic act_l);
    if (act_d !== exp_d || act_k !== exp_k || act_l !== exp_l) begin
        beat_errs++;
        $display("Error %s: expected %h/%h/%b actual %h/%h/%b",
                 name, exp_d, exp_k, exp_l, act_d, act_k, act_l);
    end
endtask

task automatic check_status(string name, status_t exp, status_t act);
    if (act !== exp) begin
        sts_errs++;
        $display("Error %s: expected %h actual %h", name, exp, act);
    end
endtask

`endif

/* tests/tx_split_tb.sv */
module tx_split_tb;
    import tx_split_cfg_pkg::*;
    import tx_split_types_pkg::*;

    localparam int NUM_CMDS       = 40;
    localparam int CYC_PER_CMD    = 300;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * CYC_PER_CMD;
    localparam int MAX_LEN        = 300;
    localparam int DRV_DLY        = 2;     // input change after the rising edge
    localparam int FIFO_ENTRIES   = 2**FIFO_DEPTH_BITS;

    logic    clk;
    logic    rstn;
    logic    meta_valid;
    logic    meta_ready;
    meta_t   meta_data;
    logic    in_valid;
    logic    in_ready;
    data_t   in_data;
    keep_t   in_keep;
    logic    in_last;
    logic    hdr_valid;
    logic    hdr_ready;
    hdr_t    hdr_data;
    logic    out_valid;
    logic    out_ready;
    data_t   out_data;
    keep_t   out_keep;
    logic    out_last;
    logic    st_in_valid;
    logic    st_in_ready;
    status_t st_in_data;
    logic    st_out_valid;
    logic    st_out_ready;
    status_t st_out_data;

    int    seed = 15541;
    meta_t cmd_q[$];
    data_t pay_data_q[$];
    keep_t pay_keep_q[$];
    logic  pay_last_q[$];

    int   cycles       = 0;
    int   cmds_started = 0;
    int   cmds_done    = 0;
    int   grants       = 0;
    int   segs_done    = 0;
    int   fifo_fill    = 0;      // beats held in the payload fifo
    logic granted      = 1'b0;   // a segment may send beats
    logic busy         = 1'b0;   // set from command accept until its final status is taken

    `include "tx_split_model.svh"

    tx_split_top dut0 (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic wait_drive_slot();
        @(posedge clk);
        #DRV_DLY;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus generation
    //////////////////////////////////////////////////////////////////////

    task automatic gen_commands();
        session_t session;
        len_t     len;
        int       beats;
        int       bytes;
        keep_t    keep;
        data_t    data;
        for (int i = 0; i < NUM_CMDS; i++) begin
            session = session_t'(rand_below(65536));
            len     = len_t'(1 + rand_below(MAX_LEN));
            beats   = (int'(len) + DATA_BYTES - 1) / DATA_BYTES;   // beats follow the length
            cmd_q.push_back({len, session});
            expect_headers(session, len);
            for (int b = 0; b < beats; b++) begin
                bytes = (b == beats - 1) ? int'(len) - b * DATA_BYTES : DATA_BYTES;
                keep  = '0;
                for (int k = 0; k < bytes; k++) begin
                    keep[k] = 1'b1;
                end
                data = {$random(seed), $random(seed)};
                pay_data_q.push_back(data);
                pay_keep_q.push_back(keep);
                pay_last_q.push_back(b == beats - 1);
                expect_beat(data, keep, b, beats);
            end
        end
    endtask

    task automatic final_report();
        int total;
        total = hdr_errs + beat_errs + sts_errs + other_errs;
        $display("errors: header %0d, beat %0d, status %0d, other %0d",
                 hdr_errs, beat_errs, sts_errs, other_errs);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin : main_seq
        rstn         = 1'b0;
        meta_valid   = 1'b0;
        meta_data    = '0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_keep      = '0;
        in_last      = 1'b0;
        hdr_ready    = 1'b0;
        out_ready    = 1'b0;
        st_in_valid  = 1'b0;
        st_in_data   = '0;
        st_out_ready = 1'b0;
        gen_commands();
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (!meta_ready || hdr_valid || st_in_ready || out_valid || st_out_valid) begin
            other_errs++;
            $display("outputs are not in their reset state during reset");
        end
        wait_drive_slot();
        rstn = 1'b1;
        wait (cmds_done == NUM_CMDS);
        repeat (20) @(posedge clk);
        if (exp_hdr_q.size() != 0 || exp_data_q.size() != 0 || exp_sts_q.size() != 0) begin
            other_errs++;
            $display("traffic missing at the end: %0d headers, %0d beats, %0d status words",
                     exp_hdr_q.size(), exp_data_q.size(), exp_sts_q.size());
        end
        if (grants != segs_done) begin
            other_errs++;
            $display("%0d segments granted but %0d segments completed", grants, segs_done);
        end
        final_report();
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("the run hung after %0d cycles with %0d of %0d commands done",
                 cycles, cmds_done, NUM_CMDS);
        other_errs++;
        final_report();
    end

    //////////////////////////////////////////////////////////////////////
    // drivers and downstream responder
    //////////////////////////////////////////////////////////////////////

    initial begin : drive_cmds
        wait (rstn);
        for (int i = 0; i < NUM_CMDS; i++) begin
            repeat (rand_below(4)) wait_drive_slot();
            meta_data  = cmd_q[i];
            meta_valid = 1'b1;
            @(negedge clk);
            while (!meta_ready) @(negedge clk);
            wait_drive_slot();
            meta_valid = 1'b0;
        end
    end

    initial begin : drive_payload
        wait (rstn);
        foreach (pay_data_q[i]) begin
            repeat (rand_below(2)) wait_drive_slot();
            in_data  = pay_data_q[i];
            in_keep  = pay_keep_q[i];
            in_last  = pay_last_q[i];
            in_valid = 1'b1;
            @(negedge clk);
            while (!in_ready) @(negedge clk);
            wait_drive_slot();
            in_valid = 1'b0;
        end
    end

    initial begin : drive_readies
        wait (rstn);
        forever begin
            out_ready    = (rand_below(4) != 0);
            hdr_ready    = (rand_below(4) != 0);
            st_out_ready = (rand_below(3) != 0);
            wait_drive_slot();
        end
    end

    initial begin : respond_status
        status_t word;
        wait (rstn);
        forever begin
            @(negedge clk);
            if (hdr_valid && hdr_ready) begin
                wait_drive_slot();
                repeat (rand_below(6)) wait_drive_slot();
                word            = {$random(seed), $random(seed)};
                word[RETRY_BIT] = (rand_below(5) == 0);   // about one retry in five
                st_in_data      = word;
                st_in_valid     = 1'b1;
                @(negedge clk);
                while (!st_in_ready) @(negedge clk);
                wait_drive_slot();
                st_in_valid = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // monitor sampling each transfer at the falling edge before it
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rstn) begin
            if (in_ready !== (fifo_fill < FIFO_ENTRIES)) begin
                other_errs++;
                $display("Error fifo in_ready: expected %b actual %b",
                         fifo_fill < FIFO_ENTRIES, in_ready);
            end
            if (in_valid && in_ready) fifo_fill++;
            if (out_valid && out_ready) fifo_fill--;
            if (busy && meta_ready) begin
                other_errs++;
                $display("meta_ready rose before the final status of command %0d was taken",
                         cmds_started - 1);
            end
            if (meta_valid && meta_ready) begin
                busy = 1'b1;
                cmds_started++;
            end
            if (hdr_valid && hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    other_errs++;
                    $display("a header was sent with no segment left to announce");
                end else begin
                    check_hdr($sformatf("cmd %0d header", cmds_started - 1),
                              exp_hdr_q[0], hdr_data);          // retry keeps the front
                end
            end
            if (out_valid && out_ready) begin
                if (!granted) begin
                    other_errs++;
                    $display("a payload beat left before its segment was granted");
                end
                if (exp_data_q.size() == 0) begin
                    other_errs++;
                    $display("a payload beat left with no beat expected");
                end else begin
                    check_beat($sformatf("cmd %0d beat", cmds_started - 1),
                               exp_data_q.pop_front(), exp_keep_q.pop_front(),
                               exp_last_q.pop_front(), out_data, out_keep, out_last);
                end
                if (out_last) begin
                    granted = 1'b0;
                    segs_done++;
                end
            end
            if (st_in_valid && st_in_ready && !st_in_data[RETRY_BIT]) begin
                granted = 1'b1;
                grants++;
                if (exp_hdr_q.size() != 0) begin
                    void'(exp_hdr_q.pop_front());
                    if (exp_final_q.pop_front()) exp_sts_q.push_back(st_in_data);
                end
            end
            if (st_out_valid && st_out_ready) begin
                if (exp_sts_q.size() == 0) begin
                    other_errs++;
                    $display("upstream status returned before the final segment was granted");
                end else begin
                    check_status($sformatf("cmd %0d status", cmds_done),
                                 exp_sts_q.pop_front(), st_out_data);
                end
                busy = 1'b0;
                cmds_done++;
            end
        end
    end

endmodule

/* tx_split_top.f */
+incdir+tests
logic/tx_split_cfg_pkg.sv
logic/tx_split_types_pkg.sv
logic/tx_split_ifs.sv
logic/cmd_decode.sv
logic/seg_sequencer.sv
logic/beat_fifo.sv
logic/seg_cutter.sv
logic/tx_split_top.sv
tests/tx_split_tb.sv
